// File: source/board_pkg.sv
package board_pkg;

	// Free-running time base shared by the whole board
	localparam int SYSTIME_BITS = 64;

	localparam int NLEDS = 8;

	// Only LED 0 lit after reset, the pattern then walks left
	localparam logic [NLEDS-1:0] LEDS_RESET = 8'b0000_0001;

endpackage

// File: source/max7219_pkg.sv
package max7219_pkg;

	localparam int WORD_BITS = 16;	// Four zero bits, address nibble, data byte
	localparam int ROWS = 8;	// Digit rows per device
	localparam logic [3:0] INTENSITY = 4'h8;
	localparam int INIT_STEPS = 5;

	typedef enum logic [3:0] {
		REG_DIGIT0 = 4'h1,
		REG_DIGIT1 = 4'h2,
		REG_DIGIT2 = 4'h3,
		REG_DIGIT3 = 4'h4,
		REG_DIGIT4 = 4'h5,
		REG_DIGIT5 = 4'h6,
		REG_DIGIT6 = 4'h7,
		REG_DIGIT7 = 4'h8,
		REG_DECODE = 4'h9,
		REG_INTENSITY = 4'hA,
		REG_SCAN_LIMIT = 4'hB,
		REG_SHUTDOWN = 4'hC,
		REG_TEST = 4'hF
	} reg_addr_e;

	// Each entry becomes one init group that is sent once after reset
	localparam reg_addr_e INIT_ADDR [INIT_STEPS] = '{
		REG_DECODE, REG_INTENSITY, REG_SCAN_LIMIT, REG_SHUTDOWN, REG_TEST
	};
	localparam logic [7:0] INIT_DATA [INIT_STEPS] = '{
		8'h00, {4'h0, INTENSITY}, 8'h07, 8'h01, 8'h00	// Raw pixels, all rows, normal mode
	};

	typedef enum logic [2:0] {ST_IDLE, ST_LOAD, ST_SHIFT, ST_LATCH, ST_GAP} ctrl_state_e;

endpackage

// File: source/systime_heartbeat.sv
`timescale 1ns/1ps

module systime_heartbeat #(
	parameter int HEARTBEAT_BIT = 20
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [board_pkg::SYSTIME_BITS-1:0] systime_set,
	input  logic systime_set_en,
	output logic [board_pkg::SYSTIME_BITS-1:0] systime,
	output logic [board_pkg::NLEDS-1:0] leds
);

	logic beat;

	// Low bits all zero once per 2**(HEARTBEAT_BIT+1) cycles
	assign beat = (systime[HEARTBEAT_BIT:0] == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			systime <= '0;
		end else if (systime_set_en) begin
			systime <= systime_set;	// Load from the host wins over counting
		end else begin
			systime <= systime + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			leds <= board_pkg::LEDS_RESET;
		end else if (beat) begin
			leds <= {leds[board_pkg::NLEDS-2:0], leds[board_pkg::NLEDS-1]};
		end
	end

endmodule

// File: source/led7219_shifter.sv
`timescale 1ns/1ps

module led7219_shifter #(
	parameter int SCLK_DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  logic word_start,
	input  max7219_pkg::reg_addr_e word_addr,
	input  logic [7:0] word_data,
	output logic word_done,
	output logic leds_out,
	output logic leds_clk
);

	localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
	localparam int BIT_W = $clog2(max7219_pkg::WORD_BITS);

	logic [max7219_pkg::WORD_BITS-1:0] shreg;
	logic [DIV_W-1:0] div_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic busy;
	logic half_end;

	assign half_end = (div_cnt == DIV_W'(SCLK_DIV - 1));
	assign leds_out = shreg[max7219_pkg::WORD_BITS-1];	// Most significant bit goes out first

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shreg <= '0;
			div_cnt <= '0;
			bit_cnt <= '0;
			busy <= 1'b0;
			leds_clk <= 1'b0;
			word_done <= 1'b0;
		end else begin
			word_done <= 1'b0;
			if (word_start && !busy) begin
				shreg <= {4'b0000, word_addr, word_data};
				div_cnt <= '0;
				bit_cnt <= '0;
				busy <= 1'b1;
			end else if (busy) begin
				if (half_end) begin
					div_cnt <= '0;
					leds_clk <= ~leds_clk;
					if (leds_clk) begin
						// Data moves on the falling edge so it is settled for the next rise
						shreg <= shreg << 1;
						if (bit_cnt == BIT_W'(max7219_pkg::WORD_BITS - 1)) begin
							busy <= 1'b0;
							word_done <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: source/led7219_ctrl.sv
`timescale 1ns/1ps

module led7219_ctrl #(
	parameter int NDEV = 4,
	parameter int SCLK_DIV = 2,
	localparam int DEV_W = (NDEV > 1) ? $clog2(NDEV) : 1,
	localparam int ROW_W = $clog2(max7219_pkg::ROWS)
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] row_byte,
	input  logic word_done,
	output logic word_start,
	output max7219_pkg::reg_addr_e word_addr,
	output logic [7:0] word_data,
	output logic leds_cs,
	output logic frame_start,
	output logic [DEV_W-1:0] dev,
	output logic [ROW_W-1:0] row
);

	localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;

	max7219_pkg::ctrl_state_e state;
	max7219_pkg::ctrl_state_e state_n;
	logic [DIV_W-1:0] div_cnt;
	logic [2:0] init_step;
	logic scan;
	logic half_end;
	logic last_init;
	logic group_end;

	assign half_end = (div_cnt == DIV_W'(SCLK_DIV - 1));
	assign last_init = (init_step == 3'(max7219_pkg::INIT_STEPS - 1));
	assign group_end = (state == max7219_pkg::ST_GAP) && half_end;

	assign word_start = (state == max7219_pkg::ST_LOAD);

	// The next group is row 0, so the frame picture is taken now
	assign frame_start = group_end && (scan ? (row == ROW_W'(max7219_pkg::ROWS - 1)) : last_init);

	assign word_addr = scan ?
		max7219_pkg::reg_addr_e'(4'(max7219_pkg::REG_DIGIT0) + 4'(row)) :
		max7219_pkg::INIT_ADDR[init_step];
	assign word_data = scan ? row_byte : max7219_pkg::INIT_DATA[init_step];

	always_comb begin
		state_n = state;
		case (state)
			max7219_pkg::ST_IDLE: begin
				state_n = max7219_pkg::ST_LOAD;
			end
			max7219_pkg::ST_LOAD: begin
				state_n = max7219_pkg::ST_SHIFT;
			end
			max7219_pkg::ST_SHIFT: begin
				if (word_done) begin
					state_n = (dev == '0) ? max7219_pkg::ST_LATCH : max7219_pkg::ST_LOAD;
				end
			end
			max7219_pkg::ST_LATCH: begin
				if (half_end) begin
					state_n = max7219_pkg::ST_GAP;
				end
			end
			max7219_pkg::ST_GAP: begin
				if (half_end) begin
					state_n = max7219_pkg::ST_LOAD;
				end
			end
			default: begin
				state_n = max7219_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= max7219_pkg::ST_IDLE;
			leds_cs <= 1'b1;
			div_cnt <= '0;
			dev <= DEV_W'(NDEV - 1);
			row <= '0;
			init_step <= '0;
			scan <= 1'b0;
		end else begin
			state <= state_n;
			// Chip select is low only while words are being loaded and shifted
			leds_cs <= !(state_n == max7219_pkg::ST_LOAD || state_n == max7219_pkg::ST_SHIFT);
			if ((state == max7219_pkg::ST_LATCH || state == max7219_pkg::ST_GAP) && !half_end) begin
				div_cnt <= div_cnt + 1'b1;
			end else begin
				div_cnt <= '0;
			end
			if (state == max7219_pkg::ST_SHIFT && word_done) begin
				dev <= (dev == '0) ? DEV_W'(NDEV - 1) : dev - 1'b1;	// Far device first
			end
			if (group_end) begin
				if (scan) begin
					row <= row + 1'b1;	// Wraps back to row 0
				end else if (last_init) begin
					scan <= 1'b1;
				end else begin
					init_step <= init_step + 1'b1;
				end
			end
		end
	end

endmodule

// File: source/led7219.sv
`timescale 1ns/1ps

module led7219 #(
	parameter int NDEV = 4,
	parameter int SCLK_DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [NDEV*64-1:0] data,
	output logic leds_out,
	output logic leds_cs,
	output logic leds_clk
);

	localparam int DEV_W = (NDEV > 1) ? $clog2(NDEV) : 1;
	localparam int ROW_W = $clog2(max7219_pkg::ROWS);
	localparam int DEV_BITS = max7219_pkg::ROWS * 8;

	logic [NDEV*64-1:0] snap;
	logic frame_start;
	logic word_start;
	logic word_done;
	logic [DEV_W-1:0] dev;
	logic [ROW_W-1:0] row;
	logic [7:0] row_byte;
	logic [7:0] word_data;
	max7219_pkg::reg_addr_e word_addr;

	// Held for a whole scan frame so all rows show the same instant
	always_ff @(posedge clk) begin
		if (frame_start) begin
			snap <= data;
		end
	end

	assign row_byte = snap[int'(dev) * DEV_BITS + int'(row) * 8 +: 8];

	led7219_ctrl #(
		.NDEV(NDEV),
		.SCLK_DIV(SCLK_DIV)
	) u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.row_byte(row_byte),
		.word_done(word_done),
		.word_start(word_start),
		.word_addr(word_addr),
		.word_data(word_data),
		.leds_cs(leds_cs),
		.frame_start(frame_start),
		.dev(dev),
		.row(row)
	);

	led7219_shifter #(
		.SCLK_DIV(SCLK_DIV)
	) u_shifter (
		.clk(clk),
		.rst_n(rst_n),
		.word_start(word_start),
		.word_addr(word_addr),
		.word_data(word_data),
		.word_done(word_done),
		.leds_out(leds_out),
		.leds_clk(leds_clk)
	);

endmodule

// File: source/debug_board.sv
`timescale 1ns/1ps

module debug_board #(
	parameter int NDEV = 4,
	parameter int SCLK_DIV = 2,
	parameter int HEARTBEAT_BIT = 20
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [(NDEV-1)*64-1:0] probe,
	input  logic [board_pkg::SYSTIME_BITS-1:0] systime_set,
	input  logic systime_set_en,
	output logic [board_pkg::SYSTIME_BITS-1:0] systime,
	output logic [board_pkg::NLEDS-1:0] leds,
	output logic leds_out,
	output logic leds_cs,
	output logic leds_clk
);

	systime_heartbeat #(
		.HEARTBEAT_BIT(HEARTBEAT_BIT)
	) u_systime (
		.clk(clk),
		.rst_n(rst_n),
		.systime_set(systime_set),
		.systime_set_en(systime_set_en),
		.systime(systime),
		.leds(leds)
	);

	// Device 0 shows the time, the remaining devices show the probed pins
	led7219 #(
		.NDEV(NDEV),
		.SCLK_DIV(SCLK_DIV)
	) u_led7219 (
		.clk(clk),
		.rst_n(rst_n),
		.data({probe, systime}),
		.leds_out(leds_out),
		.leds_cs(leds_cs),
		.leds_clk(leds_clk)
	);

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: tb/debug_board_asserts.sv
`timescale 1ns/1ps

module debug_board_asserts #(
	parameter int HEARTBEAT_BIT = 20
) (
	input logic clk,
	input logic rst_n,
	input logic [board_pkg::SYSTIME_BITS-1:0] systime_set,
	input logic systime_set_en,
	input logic [board_pkg::SYSTIME_BITS-1:0] systime,
	input logic [board_pkg::NLEDS-1:0] leds,
	input logic leds_out,
	input logic leds_cs,
	input logic leds_clk
);

	logic beat;

	assign beat = (systime[HEARTBEAT_BIT:0] == '0);

	reset_values: assert property (@(posedge clk) $rose(rst_n) |->
		(systime == '0 && leds == board_pkg::LEDS_RESET && leds_cs && !leds_clk && !leds_out))
		else $error("Outputs not at their reset values after reset release");

	systime_load: assert property (@(posedge clk) disable iff (!rst_n)
		systime_set_en |=> systime == $past(systime_set))
		else $error("systime did not take systime_set");

	systime_count: assert property (@(posedge clk) disable iff (!rst_n)
		!systime_set_en |=> systime == $past(systime) + 64'd1)
		else $error("systime did not count up by one");

	leds_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(leds))
		else $error("Heartbeat LEDs are not one-hot");

	leds_rotate: assert property (@(posedge clk) disable iff (!rst_n)
		beat |=> leds == {$past(leds[board_pkg::NLEDS-2:0]), $past(leds[board_pkg::NLEDS-1])})
		else $error("Heartbeat LEDs did not rotate left on the beat");

	leds_hold: assert property (@(posedge clk) disable iff (!rst_n) !beat |=> $stable(leds))
		else $error("Heartbeat LEDs moved without a beat");

	// The MAX7219 shifts data in on the rising serial clock
	data_stable: assert property (@(posedge clk) disable iff (!rst_n) leds_clk |-> $stable(leds_out))
		else $error("Serial data changed while the serial clock was high");

	sclk_selected: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable(leds_clk) |-> !leds_cs)
		else $error("Serial clock toggled with chip select high");

endmodule

// File: tb/debug_board_tb.sv
`timescale 1ns/1ps

module debug_board_tb;

	localparam int NDEV = 4;
	localparam int SCLK_DIV = 2;
	localparam int HEARTBEAT_BIT = 5;
	localparam int INIT_GROUPS = 5;
	localparam int GROUPS = INIT_GROUPS + 3 * 8;	// Init plus three scan frames
	localparam int LOAD_GROUPS = INIT_GROUPS + 8 + 3;	// Time load lands in row 3 of frame 1
	localparam int LOAD_FRAME = (LOAD_GROUPS - INIT_GROUPS) / 8;
	localparam int GROUP_CYCLES =
		NDEV * (max7219_pkg::WORD_BITS * 2 * SCLK_DIV + 2) + 2 * SCLK_DIV;
	localparam int TIMEOUT_CYCLES = GROUPS * GROUP_CYCLES * 7 / 4;

	logic clk;
	logic rst_n;
	logic [(NDEV-1)*64-1:0] probe;
	logic [63:0] systime_set;
	logic systime_set_en;
	logic [63:0] systime;
	logic [7:0] leds;
	logic leds_out;
	logic leds_cs;
	logic leds_clk;

	logic prev_sclk = 1'b0;
	logic prev_cs = 1'b1;
	logic [15:0] shift_word = '0;
	logic [15:0] words [NDEV];
	int bit_count = 0;
	int group_count = 0;
	int cycle_count = 0;
	logic [63:0] time_at_rise = '0;
	logic [63:0] frame_lo = '0;
	logic [63:0] frame_hi = '0;
	logic [63:0] time_snap = '0;
	logic [(NDEV-1)*64-1:0] frame_probe = '0;

	clock_gen #(.PERIOD_NS(40)) u_clock (.clk(clk));

	debug_board #(
		.NDEV(NDEV),
		.SCLK_DIV(SCLK_DIV),
		.HEARTBEAT_BIT(HEARTBEAT_BIT)
	) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.probe(probe),
		.systime_set(systime_set),
		.systime_set_en(systime_set_en),
		.systime(systime),
		.leds(leds),
		.leds_out(leds_out),
		.leds_cs(leds_cs),
		.leds_clk(leds_clk)
	);

	bind debug_board debug_board_asserts #(
		.HEARTBEAT_BIT(HEARTBEAT_BIT)
	) u_asserts (
		.clk(clk),
		.rst_n(rst_n),
		.systime_set(systime_set),
		.systime_set_en(systime_set_en),
		.systime(systime),
		.leds(leds),
		.leds_out(leds_out),
		.leds_cs(leds_cs),
		.leds_clk(leds_clk)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, expected));
	endtask

	function automatic logic [15:0] init_word(input int step);
		case (step)
			0: return {4'h0, 4'(max7219_pkg::REG_DECODE), 8'h00};
			1: return {4'h0, 4'(max7219_pkg::REG_INTENSITY), 4'h0, max7219_pkg::INTENSITY};
			2: return {4'h0, 4'(max7219_pkg::REG_SCAN_LIMIT), 8'h07};
			3: return {4'h0, 4'(max7219_pkg::REG_SHUTDOWN), 8'h01};
			default: return {4'h0, 4'(max7219_pkg::REG_TEST), 8'h00};
		endcase
	endfunction

	function automatic logic [(NDEV-1)*64-1:0] random_probe();
		logic [(NDEV-1)*64-1:0] value;
		for (int i = 0; i < (NDEV - 1) * 2; i++) begin
			value[i*32 +: 32] = $urandom;
		end
		return value;
	endfunction

	task automatic check_group(input int g);
		int row;
		int dev;
		logic [7:0] expected;
		row = (g - INIT_GROUPS) % 8;
		assert (bit_count == NDEV * 16)
			else report_mismatch($sformatf("bit_count group %0d", g), 64'(bit_count),
				64'(NDEV * 16));
		for (int i = 0; i < NDEV; i++) begin
			dev = NDEV - 1 - i;	// Far device comes first
			assert (words[i][15:12] == 4'h0)
				else report_mismatch($sformatf("words[%0d][15:12] dev %0d", i, dev),
					64'(words[i][15:12]), 64'h0);
			if (g < INIT_GROUPS) begin
				assert (words[i] == init_word(g))
					else report_mismatch($sformatf("words[%0d] group %0d dev %0d", i, g, dev),
						64'(words[i]), 64'(init_word(g)));
			end else begin
				assert (words[i][11:8] == 4'(max7219_pkg::REG_DIGIT0) + 4'(row))
					else report_mismatch($sformatf("word_addr row %0d", row),
						64'(words[i][11:8]), 64'(row + 1));
				if (dev == 0) begin
					time_snap[row*8 +: 8] = words[i][7:0];
				end else begin
					expected = frame_probe[(dev-1)*64 + row*8 +: 8];
					assert (words[i][7:0] == expected)
						else report_mismatch($sformatf("word_data dev %0d row %0d", dev, row),
							64'(words[i][7:0]), 64'(expected));
				end
			end
		end
		// After row 7 the time bytes of the frame must come from one snapshot
		if (g >= INIT_GROUPS && row == 7 && (g - INIT_GROUPS) / 8 != LOAD_FRAME) begin
			assert (time_snap >= frame_lo && time_snap <= frame_hi)
				else abort_run($sformatf("FAIL time_snap: got %h, expected %h to %h",
					time_snap, frame_lo, frame_hi));
		end
	endtask

	// The serial decoder samples mid-cycle where all outputs are settled
	always @(negedge clk) begin
		if (rst_n) begin
			if (leds_clk && !prev_sclk) begin
				shift_word = {shift_word[14:0], leds_out};
				bit_count++;
				if (bit_count % 16 == 0 && bit_count <= NDEV * 16) begin
					words[bit_count / 16 - 1] = shift_word;
				end
			end
			if (!leds_cs && prev_cs && group_count >= INIT_GROUPS
					&& (group_count - INIT_GROUPS) % 8 == 0) begin
				frame_lo = time_at_rise;
				frame_hi = systime;
				frame_probe = probe;
			end
			if (leds_cs && !prev_cs) begin
				check_group(group_count);
				group_count++;
				bit_count = 0;
				time_at_rise = systime;
			end
		end
		prev_sclk = leds_clk;
		prev_cs = leds_cs;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			abort_run($sformatf("Timeout after %0d cycles with %0d of %0d display groups seen",
				cycle_count, group_count, GROUPS));
		end
	end

	initial begin
		void'($urandom(39));
		rst_n = 1'b0;
		probe = random_probe();
		systime_set = '0;
		systime_set_en = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		wait (group_count == INIT_GROUPS + 8);
		probe = random_probe();
		wait (group_count == LOAD_GROUPS);
		systime_set = {1'b0, 31'($urandom), 32'($urandom)};	// Top bit clear keeps clear of a wrap
		systime_set_en = 1'b1;
		@(negedge clk);
		systime_set_en = 1'b0;
		wait (group_count == INIT_GROUPS + 16);
		probe = random_probe();
		wait (group_count == GROUPS);
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: debug_board.f
source/board_pkg.sv
source/max7219_pkg.sv
source/systime_heartbeat.sv
source/led7219_shifter.sv
source/led7219_ctrl.sv
source/led7219.sv
source/debug_board.sv
tb/clock_gen.sv
tb/debug_board_asserts.sv
tb/debug_board_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP := debug_board_tb
FILELIST := debug_board.f
BUILD_DIR := obj_dir
SIM_BIN := $(BUILD_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
